// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= h80_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass line appears in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
+incdir+include
verilog/h80_isa_pkg.sv
verilog/h80_bus_pkg.sv
verilog/h80_alu.sv
verilog/h80_core.sv
verilog/h80_mem.sv
verilog/h80_top.sv
test/h80_sva.sv
test/h80_tb.sv

// ==== test/h80_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_sva (
   input logic                   clk,
   input logic                   reset,
   input h80_bus_pkg::bus_addr_t bus_addr,
   input h80_bus_pkg::bus_cmd_t  bus_cmd,
   input logic                   bus_req,
   input logic                   bus_done,
   input logic                   halted
);

   // Address and command held while a transfer is outstanding
   assert property (@(posedge clk) disable iff (reset)
      (bus_req != bus_done) |=> $stable(bus_addr) && $stable(bus_cmd))
      else $error("Bus address or command changed during a transfer");

   assert property (@(posedge clk) disable iff (reset)
      halted |=> $stable(bus_req)) // No new transfer once parked
      else $error("bus_req toggled after halt");

endmodule

bind h80_core h80_sva u_sva (
   .clk      (clk),
   .reset    (reset),
   .bus_addr (bus_addr),
   .bus_cmd  (bus_cmd),
   .bus_req  (bus_req),
   .bus_done (bus_done),
   .halted   (halted)
);

`default_nettype wire

// ==== include/h80_iss.svh ====
`ifndef H80_ISS_SVH
`define H80_ISS_SVH

// Byte reads come back zero-extended
function automatic bus_data_t read_model(ref bus_data_t m[mem_words], input bus_addr_t a,
                                         input bit byte_op);
   bus_data_t w;
   w = m[a[15:1]];
   if (!byte_op)
      return w;
   return {8'h00, a[0] ? w[15:8] : w[7:0]};
endfunction

function automatic void write_model(ref bus_data_t m[mem_words], input bus_addr_t a,
                                    input bus_data_t d, input bit byte_op);
   if (!byte_op)
      m[a[15:1]] = d;
   else if (a[0])
      m[a[15:1]][15:8] = d[7:0];
   else
      m[a[15:1]][7:0] = d[7:0];
endfunction

// One instruction on the model state
function automatic void step_model(ref reg_t r[reg_numregs], ref bus_data_t m[mem_words]);
   ins_t        ins;
   reg_t        pc;
   reg_t        a;
   reg_t        b;
   logic [16:0] res;
   logic        lg;
   logic        ov;
   ins = m[r[reg_pc][15:1]];
   pc = r[reg_pc];
   a = r[ins[7:4]];
   b = r[ins[3:0]];
   r[reg_pc] = pc + 16'd2;
   if (ins == op_halt) begin
      r[reg_flag][flag_halt] = 1'b1;
   end else if (ins == op_ret) begin
      r[reg_pc] = read_model(m, r[reg_sp], 1'b0);
      r[reg_sp] += 16'd2;
   end else if (ins[15:4] == op_push || ins[15:4] == op_call) begin
      write_model(m, r[reg_sp] - 16'd2, (ins[15:4] == op_call) ? pc + 16'd2 : b, 1'b0);
      r[reg_sp] -= 16'd2;
      if (ins[15:4] == op_call)
         r[reg_pc] = b;
   end else if (ins[15:4] == op_pop) begin
      a = r[reg_sp];
      r[reg_sp] += 16'd2;
      r[ins[3:0]] = read_model(m, a, 1'b0);
   end else if (ins[15:4] == op_ld_imm) begin
      r[reg_pc] = pc + 16'd4;
      r[ins[3:0]] = read_model(m, pc + 16'd2, 1'b0);
   end else if (ins[15:6] == op_jpn || ins[15:6] == op_jp) begin
      if (r[reg_flag][ins[5:4]] == ins[6])
         r[reg_pc] = b;
   end else if (ins[15:12] == op_ld_lo) begin
      r[ins[11:8]][7:0] = ins[7:0];
   end else if (ins[15:12] == op_ld_hi) begin
      r[ins[11:8]][15:8] = ins[7:0];
   end else if (ins[15:12] == op_bus && ins[11] == 1'b0 && ins[8] == 1'b0) begin
      if (ins[9])
         write_model(m, b, a, ins[10]);
      else
         r[ins[7:4]] = read_model(m, b, ins[10]);
   end else if (ins[15:9] == op_mov_ab) begin
      r[ins[3:0]] = a;
   end else if (ins[15:9] == op_mov_ba) begin
      r[ins[7:4]] = b;
   end else if (ins[15]) begin
      case (alu_op_t'(ins[14:12]))
         ALU_ADD: res = {1'b0, a} + {1'b0, b};
         ALU_ADC: res = {1'b0, a} + {1'b0, b} + r[reg_flag][flag_carry];
         ALU_SBC: res = {1'b0, a} - {1'b0, b} - r[reg_flag][flag_carry];
         ALU_AND: res = {1'b0, a & b};
         ALU_OR:  res = {1'b0, a | b};
         ALU_XOR: res = {1'b0, a ^ b};
         default: res = {1'b0, a} - {1'b0, b};
      endcase
      // CP is a subtraction for the flags
      lg = (ins[14:12] == 3'd4) || (ins[14:12] == 3'd5) || (ins[14:12] == 3'd6);
      if (lg)
         ov = ~^res[15:0];
      else if (ins[14:12] == 3'd0 || ins[14:12] == 3'd2)
         ov = (a[15] == b[15]) && (a[15] != res[15]);
      else
         ov = (a[15] != b[15]) && (a[15] != res[15]);
      if (ins[14:12] != 3'd7)
         r[ins[11:8]] = res[15:0];
      r[reg_flag][flag_carry]    = lg ? 1'b0 : res[16];
      r[reg_flag][flag_zero]     = (res[15:0] == 16'h0000);
      r[reg_flag][flag_sign]     = res[15];
      r[reg_flag][flag_overflow] = ov;
   end
   // Anything else acts as NOP
endfunction

// Runs until HALT or the step limit
function automatic int run_model(ref reg_t r[reg_numregs], ref bus_data_t m[mem_words],
                                 input int max_steps);
   int steps;
   steps = 0;
   while (!r[reg_flag][flag_halt] && steps < max_steps) begin
      step_model(r, m);
      steps++;
   end
   return steps;
endfunction

`endif

// ==== test/h80_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_tb;
   import h80_isa_pkg::*;
   import h80_bus_pkg::*;

   `include "h80_iss.svh"

   localparam int num_programs = 20;
   localparam int data_base    = 'h2000; // Word index of byte address 0x4000
   localparam int data_words   = 128;
   localparam int iss_limit    = 10000;

   logic       clk;
   logic       reset;
   logic       load_en;
   mem_index_t load_addr;
   bus_data_t  load_data;
   logic       halted;
   reg_t       pc;
   reg_t       regs [reg_numregs];

   bus_data_t img [mem_words];   // Program and data image that later serves as model memory
   reg_t      model [reg_numregs];
   int        prog_words;
   int        sp_depth;          // Words pushed and not yet popped
   int        call_sites [$];    // Immediate words that get a routine address
   int        errors;
   int        checks;
   int        prog_num;
   int        run_limit;
   bit        running;

   h80_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .halted    (halted),
      .pc        (pc),
      .regs      (regs)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: program %0d %s is %h, expected %h",
                  $time, prog_num, what, got, exp);
      end
   endtask

   function automatic void emit_word(input bus_data_t w);
      img[prog_words] = w;
      prog_words++;
   endfunction

   // Picks from r0 to r12 only
   function automatic reg_num_t pick_reg();
      return reg_num_t'($urandom_range(12, 0));
   endfunction

   function automatic void load_imm(input reg_num_t r, input bus_data_t v);
      emit_word({op_ld_imm, r});
      emit_word(v);
   endfunction

   function automatic void simple_op();
      reg_num_t   d;
      reg_num_t   a;
      reg_num_t   b;
      logic [7:0] imm;
      d = pick_reg();
      a = pick_reg();
      b = pick_reg();
      imm = 8'($urandom);
      case ($urandom_range(7, 0))
         0: emit_word({op_ld_lo, d, imm});
         1: emit_word({op_ld_hi, d, imm});
         2: emit_word({op_mov_ab, 1'b0, a, d}); // d gets a
         3: emit_word({op_mov_ba, 1'b0, d, b}); // d gets b
         4: emit_word(op_nop);
         default: emit_word({1'b1, 3'($urandom), d, a, b});
      endcase
   endfunction

   function automatic void mem_access();
      reg_num_t   a;
      logic [1:0] cmd;
      a = reg_num_t'($urandom_range(11, 0));
      cmd = 2'($urandom);
      // Pointer in r12 may be even or odd
      load_imm(4'd12, 16'h4000 + 16'($urandom_range(191, 0)));
      emit_word({op_bus, 1'b0, cmd, 1'b0, a, 4'd12});
      if (cmd[0]) begin // Read back after a store
         emit_word({op_bus, 1'b0, 1'($urandom), 1'b0, 1'b0,
                    reg_num_t'($urandom_range(11, 0)), 4'd12});
      end
   endfunction

   function automatic void forward_branch();
      reg_num_t r;
      int       patch;
      r = pick_reg();
      load_imm(r, 16'h0000);
      patch = prog_words - 1;
      emit_word({op_jp[9:1], 1'($urandom), 2'($urandom), r}); // JP or JPN
      repeat ($urandom_range(4, 1)) simple_op();
      img[patch] = 16'(prog_words * 2);
   endfunction

   function automatic void stack_op();
      if (sp_depth > 0 && $urandom_range(1, 0) == 1) begin
         emit_word({op_pop, pick_reg()});
         sp_depth--;
      end else begin
         emit_word({op_push, pick_reg()});
         sp_depth++;
      end
   endfunction

   function automatic void call_site();
      reg_num_t r;
      r = pick_reg();
      load_imm(r, 16'h0000);
      call_sites.push_back(prog_words - 1);
      emit_word({op_call, r});
   endfunction

   function automatic void build_program();
      int items;
      prog_words = 0;
      sp_depth = 0;
      call_sites.delete();
      load_imm(reg_sp, 16'h4100); // Stack grows down into the data region
      for (int i = 0; i < 13; i++)
         load_imm(reg_num_t'(i), 16'($urandom));
      items = $urandom_range(30, 10);
      for (int i = 0; i < items; i++) begin
         case ($urandom_range(9, 0))
            0, 1: mem_access();
            2, 3: forward_branch();
            4: stack_op();
            5: call_site();
            default: simple_op();
         endcase
      end
      emit_word(op_halt);
      // Routines sit past HALT so every call goes forward
      foreach (call_sites[i]) begin
         img[call_sites[i]] = 16'(prog_words * 2);
         repeat ($urandom_range(3, 1)) simple_op();
         emit_word(op_ret);
      end
      for (int i = 0; i < data_words; i++)
         img[data_base + i] = 16'($urandom);
   endfunction

   task automatic load_word(input mem_index_t a, input bus_data_t d);
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= a;
      load_data <= d;
   endtask

   task automatic compare_state();
      check_value("halted", {15'd0, halted}, 16'd1);
      check_value("pc", pc, model[reg_pc]);
      for (int i = 0; i < reg_numregs; i++)
         check_value($sformatf("r%0d", i), regs[i], model[i]);
   endtask

   task automatic run_program();
      int steps;
      build_program();
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < prog_words; i++)
         load_word(mem_index_t'(i), img[i]);
      for (int i = 0; i < data_words; i++)
         load_word(mem_index_t'(data_base + i), img[data_base + i]);
      @(posedge clk);
      load_en <= 1'b0;
      repeat (16) @(posedge clk);
      // Model runs on the same image once the DUT has its copy
      for (int i = 0; i < reg_numregs; i++)
         model[i] = '0;
      steps = run_model(model, img, iss_limit);
      if (!model[reg_flag][flag_halt]) begin
         errors++;
         $display("Model did not reach HALT in program %0d after %0d steps", prog_num, steps);
      end
      run_limit = 40 * prog_words + 200;
      reset <= 1'b0;
      running = 1'b1;
      while (!halted)
         @(posedge clk);
      running = 1'b0;
      @(negedge clk);
      compare_state();
      repeat (100) begin // Core must stay parked
         @(negedge clk);
         check_value("halted after HALT", {15'd0, halted}, 16'd1);
         check_value("pc after HALT", pc, model[reg_pc]);
      end
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= run_limit) begin
         @(negedge clk);
         if (!running)
            cycles = 0;
         else if (!halted)
            cycles++;
      end
      $display("Timeout: program %0d did not halt within %0d cycles", prog_num, run_limit);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      reset     = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      errors    = 0;
      checks    = 0;
      running   = 1'b0;
      run_limit = 1000;
      void'($urandom(7268));
      for (prog_num = 0; prog_num < num_programs; prog_num++)
         run_program();
      $display("Programs: %0d, checks: %0d, errors: %0d", num_programs, checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/h80_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_alu (
   input  h80_isa_pkg::alu_op_t    op,
   input  h80_isa_pkg::reg_t       a,
   input  h80_isa_pkg::reg_t       b,
   input  logic                    carry_in,
   output h80_isa_pkg::reg_t       result,
   output h80_isa_pkg::alu_flags_t flags,
   output logic                    writeback
);
   import h80_isa_pkg::*;

   logic [16:0] a17;
   logic [16:0] b17;
   logic [16:0] res;
   logic        is_logic;
   logic        is_add;

   assign a17 = {1'b0, a};
   assign b17 = {1'b0, b};

   always_comb begin
      case (op)
         ALU_ADD: res = a17 + b17;
         ALU_SUB: res = a17 - b17;
         ALU_ADC: res = a17 + b17 + {16'd0, carry_in};
         ALU_SBC: res = a17 - b17 - {16'd0, carry_in};
         ALU_AND: res = a17 & b17;
         ALU_OR:  res = a17 | b17;
         ALU_XOR: res = a17 ^ b17;
         default: res = a17 - b17; // CP compares only
      endcase
   end

   assign is_logic = (op == ALU_AND) || (op == ALU_OR) || (op == ALU_XOR);
   assign is_add   = (op == ALU_ADD) || (op == ALU_ADC);

   always_comb begin
      flags[flag_carry] = is_logic ? 1'b0 : res[16];
      flags[flag_zero]  = (res[15:0] == 16'h0000);
      flags[flag_sign]  = res[15];
      if (is_logic)
         flags[flag_overflow] = ~^res[15:0]; // Even parity
      else if (is_add)
         flags[flag_overflow] = (a[15] == b[15]) && (a[15] != res[15]);
      else
         flags[flag_overflow] = (a[15] != b[15]) && (a[15] != res[15]);
   end

   assign result    = res[15:0];
   assign writeback = (op != ALU_CP);

endmodule

`default_nettype wire

// ==== verilog/h80_bus_pkg.sv ====
`default_nettype none

package h80_bus_pkg;

   typedef logic [15:0] bus_addr_t; // Byte address
   typedef logic [15:0] bus_data_t;

   // Numbered as instruction bits 11 to 9
   typedef enum logic [2:0] {
      BUS_READ_W  = 3'd0,
      BUS_WRITE_W = 3'd1,
      BUS_READ_B  = 3'd2,
      BUS_WRITE_B = 3'd3
   } bus_cmd_t;

   localparam int mem_words = 32768;

   typedef logic [14:0] mem_index_t;

endpackage

`default_nettype wire

// ==== verilog/h80_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_core (
   input  logic                   clk,
   input  logic                   reset,
   output h80_bus_pkg::bus_addr_t bus_addr,
   output h80_bus_pkg::bus_cmd_t  bus_cmd,
   output h80_bus_pkg::bus_data_t bus_wr_data,
   output logic                   bus_req,
   input  h80_bus_pkg::bus_data_t bus_rd_data,
   input  logic                   bus_done,
   output logic                   halted,
   output h80_isa_pkg::reg_t      pc,
   output h80_isa_pkg::reg_t      regs [h80_isa_pkg::reg_numregs]
);
   import h80_isa_pkg::*;
   import h80_bus_pkg::*;

   typedef enum logic {
      S_EXEC, // Fetched word ready, execute it
      S_BUS   // Data transfer completion
   } core_state_t;

   core_state_t state;
   reg_t        rf [reg_numregs];
   reg_num_t    rd_reg;       // Target of a bus read
   logic        busy;
   ins_t        ins;
   reg_t        pc_r;

   // Execute decode results
   reg_t       nxt_pc;
   logic       wr_en;
   reg_num_t   wr_num;
   reg_t       wr_val;
   logic       flag_en;
   reg_t       flag_val;
   logic       sp_en;
   reg_t       sp_val;
   logic       halt_set;
   logic       bus_go;
   bus_cmd_t   go_cmd;
   bus_addr_t  go_addr;
   bus_data_t  go_data;
   reg_num_t   go_reg;

   // Completion
   logic       is_read;
   reg_t       rd_val;
   bus_addr_t  fetch_addr;

   reg_t       alu_result;
   alu_flags_t alu_flags;
   logic       alu_wb;

   assign busy   = (bus_req != bus_done);
   assign ins    = bus_rd_data; // Held until the next completion
   assign pc_r   = rf[reg_pc];
   assign pc     = pc_r;
   assign halted = rf[reg_flag][flag_halt];
   assign regs   = rf;

   h80_alu u_alu (
      .op        (alu_op_t'(ins[14:12])),
      .a         (rf[ins[7:4]]),
      .b         (rf[ins[3:0]]),
      .carry_in  (rf[reg_flag][flag_carry]),
      .result    (alu_result),
      .flags     (alu_flags),
      .writeback (alu_wb)
   );

   always_comb begin
      nxt_pc   = pc_r + 16'd2;
      wr_en    = 1'b0;
      wr_num   = ins[11:8];
      wr_val   = alu_result;
      flag_en  = 1'b0;
      sp_en    = 1'b0;
      sp_val   = rf[reg_sp];
      halt_set = 1'b0;
      bus_go   = 1'b0;
      go_cmd   = BUS_READ_W;
      go_addr  = rf[reg_sp];
      go_data  = rf[ins[7:4]];
      go_reg   = ins[7:4];
      priority casez (ins)
         16'b0000_0000_0000_0001: halt_set = 1'b1;
         16'b0000_0000_0000_0010: begin // RET
            bus_go = 1'b1;
            go_reg = reg_pc;
            sp_en  = 1'b1;
            sp_val = rf[reg_sp] + 16'd2;
         end
         16'b0000_0001_0000_zzzz: begin // PUSH R
            bus_go  = 1'b1;
            go_cmd  = BUS_WRITE_W;
            go_addr = rf[reg_sp] - 16'd2;
            go_data = rf[ins[3:0]];
            sp_en   = 1'b1;
            sp_val  = rf[reg_sp] - 16'd2;
         end
         16'b0000_0001_0001_zzzz: begin // POP R
            bus_go = 1'b1;
            go_reg = ins[3:0];
            sp_en  = 1'b1;
            sp_val = rf[reg_sp] + 16'd2;
         end
         16'b0000_0001_0111_zzzz: begin // LD R,nnnn
            bus_go  = 1'b1;
            go_addr = pc_r + 16'd2;
            go_reg  = ins[3:0];
            nxt_pc  = pc_r + 16'd4;
         end
         16'b0000_0001_1100_zzzz: begin // CALL R
            bus_go  = 1'b1;
            go_cmd  = BUS_WRITE_W;
            go_addr = rf[reg_sp] - 16'd2;
            go_data = pc_r + 16'd2;       // Return address
            sp_en   = 1'b1;
            sp_val  = rf[reg_sp] - 16'd2;
            nxt_pc  = rf[ins[3:0]];
         end
         16'b0000_0011_00zz_zzzz: begin // JPN f,(R)
            if (!rf[reg_flag][ins[5:4]])
               nxt_pc = rf[ins[3:0]];
         end
         16'b0000_0011_01zz_zzzz: begin // JP f,(R)
            if (rf[reg_flag][ins[5:4]])
               nxt_pc = rf[ins[3:0]];
         end
         16'b0001_zzzz_zzzz_zzzz: begin
            wr_en  = 1'b1;
            wr_val = {rf[ins[11:8]][15:8], ins[7:0]};
         end
         16'b0010_zzzz_zzzz_zzzz: begin
            wr_en  = 1'b1;
            wr_val = {ins[7:0], rf[ins[11:8]][7:0]};
         end
         16'b0011_0zz0_zzzz_zzzz: begin // Word/byte transfer, address in B
            bus_go  = 1'b1;
            go_cmd  = bus_cmd_t'(ins[11:9]);
            go_addr = rf[ins[3:0]];
         end
         16'b0011_110z_zzzz_zzzz: begin // Move A to B
            wr_en  = 1'b1;
            wr_num = ins[3:0];
            wr_val = rf[ins[7:4]];
         end
         16'b0011_111z_zzzz_zzzz: begin // Move B to A
            wr_en  = 1'b1;
            wr_num = ins[7:4];
            wr_val = rf[ins[3:0]];
         end
         16'b1zzz_zzzz_zzzz_zzzz: begin
            wr_en   = alu_wb;
            flag_en = 1'b1;
         end
         default: ; // NOP, I/O transfers and unused codes
      endcase
      if (wr_en && wr_num == reg_pc)
         nxt_pc = wr_val;
      flag_val = (wr_en && wr_num == reg_flag) ? wr_val : rf[reg_flag];
      if (flag_en)
         flag_val[3:0] = alu_flags;
      if (halt_set)
         flag_val[flag_halt] = 1'b1;
   end

   assign is_read    = (bus_cmd == BUS_READ_W) || (bus_cmd == BUS_READ_B);
   assign rd_val     = (bus_cmd == BUS_READ_B) ? {8'h00, bus_rd_data[7:0]} : bus_rd_data;
   assign fetch_addr = (is_read && rd_reg == reg_pc) ? rd_val : pc_r;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < reg_numregs; i++)
            rf[i] <= '0;
         state       <= S_BUS;       // Empty completion, then fetch at 0
         bus_cmd     <= BUS_WRITE_W;
         bus_addr    <= '0;
         bus_wr_data <= '0;
         bus_req     <= 1'b0;
         rd_reg      <= '0;
      end else if (!halted && !busy) begin
         case (state)
            S_EXEC: begin
               if (wr_en)
                  rf[wr_num] <= wr_val;
               if (sp_en)
                  rf[reg_sp] <= sp_val;
               if (flag_en || halt_set)
                  rf[reg_flag] <= flag_val;
               rf[reg_pc] <= nxt_pc;
               if (bus_go) begin
                  bus_addr    <= go_addr;
                  bus_cmd     <= go_cmd;
                  bus_wr_data <= go_data;
                  rd_reg      <= go_reg;
                  bus_req     <= ~bus_req;
                  state       <= S_BUS;
               end else if (!halt_set) begin
                  bus_addr <= nxt_pc;
                  bus_cmd  <= BUS_READ_W;
                  bus_req  <= ~bus_req;
               end
            end
            S_BUS: begin
               if (is_read)
                  rf[rd_reg] <= rd_val;
               bus_addr <= fetch_addr; // Popped value after RET
               bus_cmd  <= BUS_READ_W;
               bus_req  <= ~bus_req;
               state    <= S_EXEC;
            end
            default: state <= S_EXEC;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/h80_isa_pkg.sv ====
`default_nettype none

package h80_isa_pkg;

   typedef logic [15:0] ins_t;
   typedef logic [15:0] reg_t;
   typedef logic [3:0]  reg_num_t;

   localparam int reg_numregs = 16;

   localparam reg_num_t reg_pc   = 4'd15;
   localparam reg_num_t reg_sp   = 4'd14;
   localparam reg_num_t reg_flag = 4'd13;

   // Bit positions in the flag register
   localparam int flag_carry    = 0;
   localparam int flag_zero     = 1;
   localparam int flag_sign     = 2;
   localparam int flag_overflow = 3;
   localparam int flag_halt     = 4;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_ADC = 3'd2,
      ALU_SBC = 3'd3,
      ALU_AND = 3'd4,
      ALU_OR  = 3'd5,
      ALU_XOR = 3'd6,
      ALU_CP  = 3'd7
   } alu_op_t;

   typedef logic [3:0] alu_flags_t; // overflow, sign, zero, carry

   // Whole-word opcodes
   localparam ins_t op_nop  = 16'h0000;
   localparam ins_t op_halt = 16'h0001;
   localparam ins_t op_ret  = 16'h0002;

   // Prefixes of ins[15:4]
   localparam logic [11:0] op_push   = 12'h010;
   localparam logic [11:0] op_pop    = 12'h011;
   localparam logic [11:0] op_ld_imm = 12'h017; // Word follows the instruction
   localparam logic [11:0] op_call   = 12'h01c;

   localparam logic [9:0] op_jpn = 10'b0000_0011_00; // ins[15:6]
   localparam logic [9:0] op_jp  = 10'b0000_0011_01;

   localparam logic [3:0] op_ld_lo = 4'h1; // ins[15:12]
   localparam logic [3:0] op_ld_hi = 4'h2;
   localparam logic [3:0] op_bus   = 4'h3;

   localparam logic [6:0] op_mov_ab = 7'b0011_110; // ins[15:9], A to B
   localparam logic [6:0] op_mov_ba = 7'b0011_111; // B to A

endpackage

`default_nettype wire

// ==== verilog/h80_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_mem (
   input  logic                   clk,
   input  logic                   reset,
   input  h80_bus_pkg::bus_addr_t  addr,
   input  h80_bus_pkg::bus_cmd_t   cmd,
   input  h80_bus_pkg::bus_data_t  wr_data,
   input  logic                   req,
   output logic                   done,
   output h80_bus_pkg::bus_data_t  rd_data,
   input  logic                   load_en,
   input  h80_bus_pkg::mem_index_t load_addr,
   input  h80_bus_pkg::bus_data_t  load_data
);
   import h80_bus_pkg::*;

   bus_data_t  mem [mem_words];
   mem_index_t idx;
   bus_data_t  word;
   logic       pending;

   assign idx     = addr[15:1];
   assign word    = mem[idx];
   assign pending = (req != done) && !reset;

   // Array writes, loader has priority
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end else if (pending) begin
         case (cmd)
            BUS_WRITE_W: mem[idx] <= wr_data;
            BUS_WRITE_B: begin
               if (addr[0])
                  mem[idx] <= {wr_data[7:0], word[7:0]}; // High lane
               else
                  mem[idx] <= {word[15:8], wr_data[7:0]};
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         done <= 1'b0;
      end else if (pending) begin
         done <= ~done; // Answer one cycle after the request toggle
         case (cmd)
            BUS_READ_W: rd_data <= word;
            BUS_READ_B: rd_data <= {8'h00, addr[0] ? word[15:8] : word[7:0]};
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/h80_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   load_en,
   input  h80_bus_pkg::mem_index_t load_addr,
   input  h80_bus_pkg::bus_data_t  load_data,
   output logic                   halted,
   output h80_isa_pkg::reg_t       pc,
   output h80_isa_pkg::reg_t       regs [h80_isa_pkg::reg_numregs]
);
   import h80_bus_pkg::*;

   bus_addr_t bus_addr;
   bus_cmd_t  bus_cmd;
   bus_data_t bus_wr_data;
   bus_data_t bus_rd_data;
   logic      bus_req;
   logic      bus_done;

   h80_core u_core (
      .clk         (clk),
      .reset       (reset),
      .bus_addr    (bus_addr),
      .bus_cmd     (bus_cmd),
      .bus_wr_data (bus_wr_data),
      .bus_req     (bus_req),
      .bus_rd_data (bus_rd_data),
      .bus_done    (bus_done),
      .halted      (halted),
      .pc          (pc),
      .regs        (regs)
   );

   h80_mem u_mem (
      .clk       (clk),
      .reset     (reset),
      .addr      (bus_addr),
      .cmd       (bus_cmd),
      .wr_data   (bus_wr_data),
      .req       (bus_req),
      .done      (bus_done),
      .rd_data   (bus_rd_data),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

`default_nettype wire
